/* hdl/aplic_types_pkg.sv */
// ====================
// Source counts, vector types and command kinds shared by the
// APLIC register controller blocks
// ====================
`default_nettype none

package aplic_types_pkg;

  // Source slots, id 0 is reserved
  localparam int NR_SRC     = 32;
  localparam int NR_DOMAINS = 2;

  localparam int SRC_ID_W   = $clog2(NR_SRC);
  localparam int SRC_MODE_W = 3;
  localparam int DOMAIN_W   = $clog2(NR_DOMAINS);
  localparam int BUS_ADDR_W = 14;
  localparam int BUS_DATA_W = 32;

  typedef logic [NR_SRC-1:0]     src_vec_t;
  typedef logic [SRC_ID_W-1:0]   src_id_t;
  typedef logic [SRC_MODE_W-1:0] src_mode_t;
  typedef logic [NR_DOMAINS-1:0] dom_vec_t;
  // 0 is M, 1 is S
  typedef logic [DOMAIN_W-1:0]   domain_t;
  typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [BUS_DATA_W-1:0] bus_data_t;

  // Decoded write kinds
  typedef enum logic [3:0] {
    NONE      = 4'd0,
    DOMAINCFG = 4'd1,
    SOURCECFG = 4'd2,
    SETIP     = 4'd3,
    SETIPNUM  = 4'd4,
    CLRIP     = 4'd5,
    CLRIPNUM  = 4'd6,
    SETIE     = 4'd7,
    SETIENUM  = 4'd8,
    CLRIE     = 4'd9,
    CLRIENUM  = 4'd10
  } cmd_op_t;

endpackage

`default_nettype wire

/* hdl/aplic_regmap_pkg.sv */
// ====================
// Register byte offsets and field positions of the APLIC domain map
// ====================
`default_nettype none

package aplic_regmap_pkg;

  localparam aplic_types_pkg::bus_addr_t DOMAINCFG_OFS = 14'h0000;

  // Source k lives at SOURCECFG_OFS + 4*(k-1)
  localparam aplic_types_pkg::bus_addr_t SOURCECFG_OFS = 14'h0004;
  localparam aplic_types_pkg::bus_addr_t SOURCECFG_LAST_OFS =
    SOURCECFG_OFS + 14'(4 * (aplic_types_pkg::NR_SRC - 2));

  // Pending registers
  localparam aplic_types_pkg::bus_addr_t SETIP_OFS     = 14'h1C00;
  localparam aplic_types_pkg::bus_addr_t SETIPNUM_OFS  = 14'h1CDC;
  localparam aplic_types_pkg::bus_addr_t IN_CLRIP_OFS  = 14'h1D00;
  localparam aplic_types_pkg::bus_addr_t CLRIPNUM_OFS  = 14'h1DDC;

  // Enable registers
  localparam aplic_types_pkg::bus_addr_t SETIE_OFS     = 14'h1E00;
  localparam aplic_types_pkg::bus_addr_t SETIENUM_OFS  = 14'h1EDC;
  localparam aplic_types_pkg::bus_addr_t CLRIE_OFS     = 14'h1F00;
  localparam aplic_types_pkg::bus_addr_t CLRIENUM_OFS  = 14'h1FDC;

  // Field positions
  localparam int DCFG_IE_BIT = 8;
  localparam int SCFG_D_BIT  = 10;
  localparam int SCFG_SM_LSB = 0;

endpackage

`default_nettype wire

/* hdl/aplic_cmd_if.sv */
// ====================
// Decoded command bus from the write decoder to the source store
// and the pending/enable controller
// ====================
`timescale 1ns/1ps
`default_nettype none

interface aplic_cmd_if;

  // One-cycle level, no handshake
  logic                       cmd_valid;
  aplic_types_pkg::cmd_op_t   cmd_op;
  aplic_types_pkg::domain_t   cmd_domain;
  aplic_types_pkg::src_id_t   cmd_src;
  aplic_types_pkg::bus_data_t cmd_data;

  modport decode (output cmd_valid, cmd_op, cmd_domain, cmd_src, cmd_data);

  modport store (input cmd_valid, cmd_op, cmd_domain, cmd_src, cmd_data);

  // Numbered commands carry the id in cmd_data
  modport ctl (input cmd_valid, cmd_op, cmd_domain, cmd_data);

endinterface

`default_nettype wire

/* hdl/aplic_cfg_decode.sv */
// ====================
// Write decoder: turns bus writes into registered commands and
// keeps the per-domain interrupt enable bits of domaincfg
// ====================
`timescale 1ns/1ps
`default_nettype none

module aplic_cfg_decode (
  input  wire logic                       i_clk,
  input  wire logic                       ni_rst,
  input  wire logic                       i_wr_en,
  input  wire aplic_types_pkg::bus_addr_t i_wr_addr,
  input  wire aplic_types_pkg::bus_data_t i_wr_data,
  input  wire aplic_types_pkg::domain_t   i_wr_domain,
  aplic_cmd_if.decode                     cmd,
  output aplic_types_pkg::dom_vec_t       o_domain_ie
);

  aplic_types_pkg::cmd_op_t   op_d;
  aplic_types_pkg::src_id_t   src_d;
  aplic_types_pkg::bus_addr_t scfg_rel;
  aplic_types_pkg::dom_vec_t  dom_ie_q;
  logic                       scfg_hit;

  // Sourcecfg window, word aligned, ids 1 to 31
  assign scfg_rel = i_wr_addr - aplic_regmap_pkg::SOURCECFG_OFS;
  assign scfg_hit = (i_wr_addr >= aplic_regmap_pkg::SOURCECFG_OFS) &&
                    (i_wr_addr <= aplic_regmap_pkg::SOURCECFG_LAST_OFS) &&
                    (i_wr_addr[1:0] == 2'b00);

  always_comb begin
    op_d  = aplic_types_pkg::NONE;
    src_d = '0;
    if (i_wr_en) begin
      case (i_wr_addr)
        aplic_regmap_pkg::DOMAINCFG_OFS: op_d = aplic_types_pkg::DOMAINCFG;
        aplic_regmap_pkg::SETIP_OFS:     op_d = aplic_types_pkg::SETIP;
        aplic_regmap_pkg::SETIPNUM_OFS:  op_d = aplic_types_pkg::SETIPNUM;
        aplic_regmap_pkg::IN_CLRIP_OFS:  op_d = aplic_types_pkg::CLRIP;
        aplic_regmap_pkg::CLRIPNUM_OFS:  op_d = aplic_types_pkg::CLRIPNUM;
        aplic_regmap_pkg::SETIE_OFS:     op_d = aplic_types_pkg::SETIE;
        aplic_regmap_pkg::SETIENUM_OFS:  op_d = aplic_types_pkg::SETIENUM;
        aplic_regmap_pkg::CLRIE_OFS:     op_d = aplic_types_pkg::CLRIE;
        aplic_regmap_pkg::CLRIENUM_OFS:  op_d = aplic_types_pkg::CLRIENUM;
        default: begin
          if (scfg_hit) begin
            op_d  = aplic_types_pkg::SOURCECFG;
            src_d = scfg_rel[2 +: aplic_types_pkg::SRC_ID_W] + 1'b1;
          end
        end
      endcase
    end
  end

  // ====================
  // Command and domaincfg registers
  // ====================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      cmd.cmd_valid <= 1'b0;
      cmd.cmd_op    <= aplic_types_pkg::NONE;
      dom_ie_q      <= '0;
    end else begin
      cmd.cmd_valid <= (op_d != aplic_types_pkg::NONE);
      cmd.cmd_op    <= op_d;
      if (op_d == aplic_types_pkg::DOMAINCFG) begin
        dom_ie_q[i_wr_domain] <= i_wr_data[aplic_regmap_pkg::DCFG_IE_BIT];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    cmd.cmd_domain <= i_wr_domain;
    cmd.cmd_src    <= src_d;
    cmd.cmd_data   <= i_wr_data;
  end

  assign o_domain_ie = dom_ie_q;

  // Store and controller never see an empty command
  a_valid_has_op : assert property (@(posedge i_clk) disable iff (!ni_rst)
    cmd.cmd_valid |-> (cmd.cmd_op != aplic_types_pkg::NONE));

endmodule

`default_nettype wire

/* hdl/aplic_source_cfg.sv */
// ====================
// Per-source delegation and mode store, drives ownership and
// active vectors to the pending/enable controller
// ====================
`timescale 1ns/1ps
`default_nettype none

module aplic_source_cfg (
  input  wire logic                 i_clk,
  input  wire logic                 ni_rst,
  aplic_cmd_if.store                cmd,
  output aplic_types_pkg::src_vec_t o_owner,
  output aplic_types_pkg::src_vec_t o_active
);

  aplic_types_pkg::src_vec_t  deleg_q;
  aplic_types_pkg::src_mode_t mode_q [1:aplic_types_pkg::NR_SRC-1];
  aplic_types_pkg::src_vec_t  active;
  aplic_types_pkg::src_mode_t wr_mode;
  logic                       wr_deleg;
  logic                       scfg_wr;
  logic                       wr_accept;

  // Fields of the incoming sourcecfg word
  assign wr_deleg = cmd.cmd_data[aplic_regmap_pkg::SCFG_D_BIT];
  assign wr_mode  = wr_deleg ? '0 :
    cmd.cmd_data[aplic_regmap_pkg::SCFG_SM_LSB +: aplic_types_pkg::SRC_MODE_W];

  assign scfg_wr = cmd.cmd_valid &&
                   (cmd.cmd_op == aplic_types_pkg::SOURCECFG) &&
                   (cmd.cmd_src != '0);

  // M may always write, S only on a source delegated to it
  always_comb begin
    wr_accept = 1'b0;
    if (scfg_wr) begin
      if (cmd.cmd_domain == 1'b0) begin
        wr_accept = 1'b1;
      end else begin
        wr_accept = deleg_q[cmd.cmd_src];
      end
    end
  end

  // ====================
  // Delegation and mode state
  // ====================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      deleg_q <= '0;
      for (int k = 1; k < aplic_types_pkg::NR_SRC; k++) begin
        mode_q[k] <= '0;
      end
    end else if (wr_accept) begin
      mode_q[cmd.cmd_src] <= wr_mode;
      // Only M moves a source between domains
      if (cmd.cmd_domain == 1'b0) begin
        deleg_q[cmd.cmd_src] <= wr_deleg;
      end
    end
  end

  // A source is active when its mode is not inactive
  always_comb begin
    active = '0;
    for (int k = 1; k < aplic_types_pkg::NR_SRC; k++) begin
      active[k] = (mode_q[k] != '0);
    end
  end

  assign o_owner  = deleg_q;
  assign o_active = active;

  // Reserved id 0 never becomes a live source
  a_src0_inactive : assert property (@(posedge i_clk) disable iff (!ni_rst)
    !o_active[0] && !o_owner[0]);

endmodule

`default_nettype wire

/* hdl/aplic_ip_ie_ctl.sv */
// ====================
// Pending and enable controller: applies word and numbered
// commands and gateway pulses, and raises per-domain requests
// ====================
`timescale 1ns/1ps
`default_nettype none

module aplic_ip_ie_ctl (
  input  wire logic                      i_clk,
  input  wire logic                      ni_rst,
  aplic_cmd_if.ctl                       cmd,
  input  wire aplic_types_pkg::src_vec_t i_owner,
  input  wire aplic_types_pkg::src_vec_t i_active,
  input  wire aplic_types_pkg::src_vec_t i_src_pend,
  input  wire aplic_types_pkg::dom_vec_t i_domain_ie,
  output aplic_types_pkg::src_vec_t      o_pending,
  output aplic_types_pkg::src_vec_t      o_enabled,
  output aplic_types_pkg::dom_vec_t      o_irq
);

  aplic_types_pkg::src_vec_t pend_q;
  aplic_types_pkg::src_vec_t pend_d;
  aplic_types_pkg::src_vec_t en_q;
  aplic_types_pkg::src_vec_t en_d;
  aplic_types_pkg::src_vec_t own_vec [aplic_types_pkg::NR_DOMAINS];
  aplic_types_pkg::src_vec_t wr_own;
  aplic_types_pkg::src_vec_t word_mask;
  aplic_types_pkg::src_vec_t num_mask;
  aplic_types_pkg::src_id_t  num_id;
  aplic_types_pkg::dom_vec_t irq;
  logic                      num_in_range;

  // Sources owned by each domain
  always_comb begin
    for (int d = 0; d < aplic_types_pkg::NR_DOMAINS; d++) begin
      for (int k = 0; k < aplic_types_pkg::NR_SRC; k++) begin
        own_vec[d][k] = (i_owner[k] == aplic_types_pkg::domain_t'(d));
      end
    end
  end

  assign wr_own = own_vec[cmd.cmd_domain];

  // Word commands touch only bits the writer owns
  assign word_mask = cmd.cmd_data & wr_own;

  // Numbered commands need an id from 1 to 31
  assign num_id       = cmd.cmd_data[aplic_types_pkg::SRC_ID_W-1:0];
  assign num_in_range = (cmd.cmd_data < aplic_types_pkg::NR_SRC) &&
                        (cmd.cmd_data != '0);
  assign num_mask     = num_in_range ?
                        ((aplic_types_pkg::src_vec_t'(1) << num_id) & wr_own) : '0;

  // ====================
  // Next pending and enable state
  // ====================
  always_comb begin
    pend_d = pend_q;
    en_d   = en_q;
    if (cmd.cmd_valid) begin
      case (cmd.cmd_op)
        aplic_types_pkg::SETIP:    pend_d = pend_q | word_mask;
        aplic_types_pkg::SETIPNUM: pend_d = pend_q | num_mask;
        aplic_types_pkg::CLRIP:    pend_d = pend_q & ~word_mask;
        aplic_types_pkg::CLRIPNUM: pend_d = pend_q & ~num_mask;
        aplic_types_pkg::SETIE:    en_d   = en_q | word_mask;
        aplic_types_pkg::SETIENUM: en_d   = en_q | num_mask;
        aplic_types_pkg::CLRIE:    en_d   = en_q & ~word_mask;
        aplic_types_pkg::CLRIENUM: en_d   = en_q & ~num_mask;
        default: begin
          pend_d = pend_q;
          en_d   = en_q;
        end
      endcase
    end
    // Gateway pulses, then drop anything on an inactive source
    pend_d = (pend_d | i_src_pend) & i_active;
    en_d   = en_d & i_active;
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      pend_q <= '0;
      en_q   <= '0;
    end else begin
      pend_q <= pend_d;
      en_q   <= en_d;
    end
  end

  // Request when an owned source is both pending and enabled
  always_comb begin
    for (int d = 0; d < aplic_types_pkg::NR_DOMAINS; d++) begin
      irq[d] = i_domain_ie[d] && (|(pend_q & en_q & own_vec[d]));
    end
  end

  assign o_pending = pend_q;
  assign o_enabled = en_q;
  assign o_irq     = irq;

  // Enable bits only follow the active vector of the cycle before
  a_en_active : assert property (@(posedge i_clk) disable iff (!ni_rst)
    (o_enabled & ~$past(i_active)) == '0);

endmodule

`default_nettype wire

/* hdl/aplic_regctl.sv */
// ====================
// APLIC register controller top, M and S domains, 31 sources
// ====================
`timescale 1ns/1ps
`default_nettype none

module aplic_regctl (
  input  wire logic                       i_clk,
  input  wire logic                       ni_rst,
  // Bus write port
  input  wire logic                       i_wr_en,
  input  wire aplic_types_pkg::bus_addr_t i_wr_addr,
  input  wire aplic_types_pkg::bus_data_t i_wr_data,
  input  wire aplic_types_pkg::domain_t   i_wr_domain,
  // Gateway pulses
  input  wire aplic_types_pkg::src_vec_t  i_src_pend,
  // Status and requests
  output aplic_types_pkg::src_vec_t       o_active,
  output aplic_types_pkg::src_vec_t       o_deleg,
  output aplic_types_pkg::src_vec_t       o_pending,
  output aplic_types_pkg::src_vec_t       o_enabled,
  output aplic_types_pkg::dom_vec_t       o_domain_ie,
  output aplic_types_pkg::dom_vec_t       o_irq
);

  aplic_types_pkg::src_vec_t owner;
  aplic_types_pkg::src_vec_t active;
  aplic_types_pkg::dom_vec_t domain_ie;

  aplic_cmd_if cmd_bus ();

  aplic_cfg_decode u_decode (
    .i_clk       (i_clk),
    .ni_rst      (ni_rst),
    .i_wr_en     (i_wr_en),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .i_wr_domain (i_wr_domain),
    .cmd         (cmd_bus.decode),
    .o_domain_ie (domain_ie)
  );

  aplic_source_cfg u_source_cfg (
    .i_clk    (i_clk),
    .ni_rst   (ni_rst),
    .cmd      (cmd_bus.store),
    .o_owner  (owner),
    .o_active (active)
  );

  aplic_ip_ie_ctl u_ip_ie_ctl (
    .i_clk       (i_clk),
    .ni_rst      (ni_rst),
    .cmd         (cmd_bus.ctl),
    .i_owner     (owner),
    .i_active    (active),
    .i_src_pend  (i_src_pend),
    .i_domain_ie (domain_ie),
    .o_pending   (o_pending),
    .o_enabled   (o_enabled),
    .o_irq       (o_irq)
  );

  // Delegated sources are the ones S owns
  assign o_deleg     = owner;
  assign o_active    = active;
  assign o_domain_ie = domain_ie;

endmodule

`default_nettype wire

/* sim/aplic_tests.svh */
// ====================
// Directed tests, included inside the testbench module
// ====================
`ifndef APLIC_TESTS_SVH
`define APLIC_TESTS_SVH

// Sources 3 and 7 become active under M
task automatic reset_and_source_config();
  check_outputs("reset values");
  bus_write(scfg_addr(3), aplic_types_pkg::bus_data_t'(1), DOM_M);
  bus_write(scfg_addr(7), aplic_types_pkg::bus_data_t'(1), DOM_M);
  exp_active[3] = 1'b1;
  exp_active[7] = 1'b1;
  check_outputs("M sourcecfg 3 and 7");
endtask

task automatic numbered_pending_enable();
  bus_write(aplic_regmap_pkg::DOMAINCFG_OFS,
            aplic_types_pkg::bus_data_t'(1) << aplic_regmap_pkg::DCFG_IE_BIT, DOM_M);
  exp_ie[0] = 1'b1;
  check_outputs("M domaincfg IE");
  bus_write(aplic_regmap_pkg::SETIENUM_OFS, aplic_types_pkg::bus_data_t'(3), DOM_M);
  bus_write(aplic_regmap_pkg::SETIPNUM_OFS, aplic_types_pkg::bus_data_t'(3), DOM_M);
  exp_en[3]   = 1'b1;
  exp_pend[3] = 1'b1;
  exp_irq[0]  = 1'b1;
  check_outputs("setienum and setipnum 3");
  bus_write(aplic_regmap_pkg::CLRIPNUM_OFS, aplic_types_pkg::bus_data_t'(3), DOM_M);
  exp_pend[3] = 1'b0;
  exp_irq[0]  = 1'b0;
  check_outputs("clripnum 3");
endtask

task automatic word_enable_writes();
  aplic_types_pkg::bus_data_t rnd;
  aplic_types_pkg::src_id_t   id;
  // Random word that always covers the active sources
  rnd = $urandom | exp_active;
  // Only active sources owned by M may take the enable
  bus_write(aplic_regmap_pkg::SETIE_OFS, rnd, DOM_M);
  exp_en = exp_en | (rnd & exp_active & ~exp_deleg);
  check_outputs("setie random word");
  bus_write(aplic_regmap_pkg::CLRIE_OFS, rnd, DOM_M);
  exp_en = exp_en & ~(rnd & ~exp_deleg);
  check_outputs("clrie random word");
  bus_write(aplic_regmap_pkg::SETIPNUM_OFS, '0, DOM_M);
  check_outputs("setipnum 0");
  // Id 35 matches source 3 in its low bits
  bus_write(aplic_regmap_pkg::SETIPNUM_OFS, aplic_types_pkg::bus_data_t'(32 + 3), DOM_M);
  check_outputs("setipnum above 31");
  // Random inactive source id
  id = aplic_types_pkg::src_id_t'(($urandom % 31) + 1);
  while (exp_active[id]) begin
    id = aplic_types_pkg::src_id_t'(($urandom % 31) + 1);
  end
  bus_write(aplic_regmap_pkg::SETIPNUM_OFS, aplic_types_pkg::bus_data_t'(id), DOM_M);
  check_outputs("setipnum inactive source");
endtask

task automatic s_domain_delegation();
  bus_write(scfg_addr(5),
            aplic_types_pkg::bus_data_t'(1) << aplic_regmap_pkg::SCFG_D_BIT, DOM_M);
  exp_deleg[5] = 1'b1;
  check_outputs("M delegates 5");
  bus_write(scfg_addr(5), aplic_types_pkg::bus_data_t'(4), DOM_S);
  exp_active[5] = 1'b1;
  check_outputs("S sourcecfg 5 mode 4");
  bus_write(aplic_regmap_pkg::SETIPNUM_OFS, aplic_types_pkg::bus_data_t'(5), DOM_S);
  bus_write(aplic_regmap_pkg::SETIENUM_OFS, aplic_types_pkg::bus_data_t'(5), DOM_S);
  bus_write(aplic_regmap_pkg::DOMAINCFG_OFS,
            aplic_types_pkg::bus_data_t'(1) << aplic_regmap_pkg::DCFG_IE_BIT, DOM_S);
  exp_pend[5] = 1'b1;
  exp_en[5]   = 1'b1;
  exp_ie[1]   = 1'b1;
  exp_irq[1]  = 1'b1;
  check_outputs("S request on source 5");
  // Source 5 now belongs to S
  bus_write(aplic_regmap_pkg::CLRIPNUM_OFS, aplic_types_pkg::bus_data_t'(5), DOM_M);
  bus_write(aplic_regmap_pkg::CLRIENUM_OFS, aplic_types_pkg::bus_data_t'(5), DOM_M);
  check_outputs("M numbered writes to 5");
endtask

task automatic gateway_pulses();
  @(posedge i_clk);
  #1;
  i_src_pend    = '0;
  i_src_pend[7] = 1'b1;
  i_src_pend[9] = 1'b1;
  @(posedge i_clk);
  #1;
  i_src_pend = '0;
  @(posedge i_clk);
  #1;
  exp_pend[7] = 1'b1;
  check_outputs("gateway pulses 7 and 9");
  bus_write(aplic_regmap_pkg::SETIP_OFS, aplic_types_pkg::bus_data_t'(32'h88), DOM_S);
  check_outputs("S setip to M sources");
endtask

`endif

/* sim/tb_aplic_regctl.sv */
// ====================
// Testbench for the APLIC register controller, runs the
// directed tests from the included test file
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_aplic_regctl;

  localparam int HALF_NS      = 2;
  localparam int CLK_NS       = 2 * HALF_NS;
  localparam int RESET_CYCLES = 16;
  // 19 writes of 5 cycles each, plus reset and pulse cycles
  localparam int TEST_CYCLES  = RESET_CYCLES + 19 * 5 + 20;
  localparam int MARGIN_NS    = 200;
  localparam int RAND_SEED    = 32'h2d86;

  localparam aplic_types_pkg::domain_t DOM_M = 1'b0;
  localparam aplic_types_pkg::domain_t DOM_S = 1'b1;

  logic                       i_clk;
  logic                       ni_rst;
  logic                       i_wr_en;
  aplic_types_pkg::bus_addr_t i_wr_addr;
  aplic_types_pkg::bus_data_t i_wr_data;
  aplic_types_pkg::domain_t   i_wr_domain;
  aplic_types_pkg::src_vec_t  i_src_pend;
  aplic_types_pkg::src_vec_t  o_active;
  aplic_types_pkg::src_vec_t  o_deleg;
  aplic_types_pkg::src_vec_t  o_pending;
  aplic_types_pkg::src_vec_t  o_enabled;
  aplic_types_pkg::dom_vec_t  o_domain_ie;
  aplic_types_pkg::dom_vec_t  o_irq;

  // Expected state, kept by the tests
  aplic_types_pkg::src_vec_t  exp_active;
  aplic_types_pkg::src_vec_t  exp_deleg;
  aplic_types_pkg::src_vec_t  exp_pend;
  aplic_types_pkg::src_vec_t  exp_en;
  aplic_types_pkg::dom_vec_t  exp_ie;
  aplic_types_pkg::dom_vec_t  exp_irq;

  aplic_regctl DUT (
    .i_clk       (i_clk),
    .ni_rst      (ni_rst),
    .i_wr_en     (i_wr_en),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .i_wr_domain (i_wr_domain),
    .i_src_pend  (i_src_pend),
    .o_active    (o_active),
    .o_deleg     (o_deleg),
    .o_pending   (o_pending),
    .o_enabled   (o_enabled),
    .o_domain_ie (o_domain_ie),
    .o_irq       (o_irq)
  );

  always #HALF_NS i_clk = ~i_clk;

  // ====================
  // Bus and compare helpers
  // ====================
  function automatic aplic_types_pkg::bus_addr_t scfg_addr(input int k);
    return aplic_regmap_pkg::SOURCECFG_OFS + aplic_types_pkg::bus_addr_t'(4 * (k - 1));
  endfunction

  // One strobe, then three cycles for the result to settle
  task automatic bus_write(input aplic_types_pkg::bus_addr_t addr,
                           input aplic_types_pkg::bus_data_t data,
                           input aplic_types_pkg::domain_t dom);
    @(posedge i_clk);
    #1;
    i_wr_en     = 1'b1;
    i_wr_addr   = addr;
    i_wr_data   = data;
    i_wr_domain = dom;
    @(posedge i_clk);
    #1;
    i_wr_en = 1'b0;
    repeat (3) @(posedge i_clk);
    #1;
  endtask

  task automatic check_vec(input string name, input aplic_types_pkg::src_vec_t exp,
                           input aplic_types_pkg::src_vec_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %08h actual %08h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "Source vector mismatch in %s", name);
    end
  endtask

  task automatic check_dom(input string name, input aplic_types_pkg::dom_vec_t exp,
                           input aplic_types_pkg::dom_vec_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %02b actual %02b", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "Domain vector mismatch in %s", name);
    end
  endtask

  task automatic check_outputs(input string name);
    check_vec({name, " active"}, exp_active, o_active);
    check_vec({name, " deleg"}, exp_deleg, o_deleg);
    check_vec({name, " pending"}, exp_pend, o_pending);
    check_vec({name, " enabled"}, exp_en, o_enabled);
    check_dom({name, " domain_ie"}, exp_ie, o_domain_ie);
    check_dom({name, " irq"}, exp_irq, o_irq);
  endtask

  `include "aplic_tests.svh"

  initial begin
    #(TEST_CYCLES * CLK_NS + MARGIN_NS);
    $display("Watchdog expired before the directed tests finished");
    $display("TEST FAILED");
    $fatal(1, "Simulation timeout");
  end

  initial begin
    void'($urandom(RAND_SEED));
    i_clk       = 1'b0;
    ni_rst      = 1'b0;
    i_wr_en     = 1'b0;
    i_wr_addr   = '0;
    i_wr_data   = '0;
    i_wr_domain = DOM_M;
    i_src_pend  = '0;
    exp_active  = '0;
    exp_deleg   = '0;
    exp_pend    = '0;
    exp_en      = '0;
    exp_ie      = '0;
    exp_irq     = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #1;
    ni_rst = 1'b1;
    reset_and_source_config();
    numbered_pending_enable();
    word_enable_writes();
    s_domain_delegation();
    gateway_pulses();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* aplic_regctl.f */
+incdir+sim
hdl/aplic_types_pkg.sv
hdl/aplic_regmap_pkg.sv
hdl/aplic_cmd_if.sv
hdl/aplic_cfg_decode.sv
hdl/aplic_source_cfg.sv
hdl/aplic_ip_ie_ctl.sv
hdl/aplic_regctl.sv
sim/tb_aplic_regctl.sv

/* Makefile */
# Verilator build and run for the APLIC register controller

VERILATOR ?= verilator
TOP       ?= tb_aplic_regctl
FILELIST  ?= aplic_regctl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
